/* hw/sq_doorbell.sv */
`timescale 1ns/1ns

module sq_doorbell (
  input  logic                axil_aclk_i,
  input  logic                rstn_i,
  input  logic                db_valid_i,
  input  wqm_pkg::doorbell_t  db_i,
  output logic                db_ready_o,
  output logic                fetch_valid_o,
  output wqm_pkg::fetch_req_t fetch_o,
  input  logic                fetch_ready_i
);

  import wqm_pkg::*;

  // Per-queue ring state
  logic [IDX_W-1:0]    prod_idx_q    [NUM_SQ];
  logic [IDX_W-1:0]    issued_idx_q  [NUM_SQ];
  logic [ADDR_W-1:0]   base_addr_q   [NUM_SQ];
  logic [ADDR_W-1:0]   local_vaddr_q [NUM_SQ];

  logic                db_accept;
  logic                pend_any;
  logic [SQ_IDX_W-1:0] pend_sel;
  logic                load_out;
  logic [ADDR_W-1:0]   wqe_addr;
  logic                fetch_valid_q;
  fetch_req_t          fetch_q;

  assign db_ready_o = 1'b1;

  // Only a higher producer index counts as new work
  assign db_accept = db_valid_i && (db_i.prod_idx > prod_idx_q[db_i.sq_idx]);

  // Lowest-numbered queue with work pending wins
  always_comb begin
    pend_any = 1'b0;
    pend_sel = '0;
    for (int i = NUM_SQ - 1; i >= 0; i--) begin
      if (issued_idx_q[i] < prod_idx_q[i]) begin
        pend_any = 1'b1;
        pend_sel = SQ_IDX_W'(i);
      end
    end
  end

  // Output slot empty or draining this cycle
  assign load_out = pend_any && (!fetch_valid_q || fetch_ready_i);

  // Base plus index times WQE stride
  assign wqe_addr = base_addr_q[pend_sel]
                    + ADDR_W'(issued_idx_q[pend_sel]) * ADDR_W'(WQE_BYTES);

  //////////////////////////////
  // Index tracking
  //////////////////////////////

  always_ff @(posedge axil_aclk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      for (int i = 0; i < NUM_SQ; i++) begin
        prod_idx_q[i]   <= '0;
        issued_idx_q[i] <= '0;
      end
      fetch_valid_q <= 1'b0;
    end else begin
      if (db_accept) begin
        prod_idx_q[db_i.sq_idx] <= db_i.prod_idx;
      end
      // Index counts as issued once it sits in the output slot
      if (load_out) begin
        issued_idx_q[pend_sel] <= issued_idx_q[pend_sel] + 1'b1;
        fetch_valid_q          <= 1'b1;
      end else if (fetch_ready_i) begin
        fetch_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge axil_aclk_i) begin
    if (db_accept) begin
      base_addr_q[db_i.sq_idx]   <= db_i.base_addr;
      local_vaddr_q[db_i.sq_idx] <= db_i.local_vaddr;
    end
    if (load_out) begin
      fetch_q.sq_idx      <= pend_sel;
      fetch_q.wqe_addr    <= wqe_addr;
      fetch_q.local_vaddr <= local_vaddr_q[pend_sel];
    end
  end

  assign fetch_valid_o = fetch_valid_q;
  assign fetch_o       = fetch_q;

endmodule

/* hw/wq_manager_top.sv */
`timescale 1ns/1ns

module wq_manager_top (
  input  logic                      axil_aclk_i,
  input  logic                      rstn_i,
  input  logic                      db_valid_i,
  input  wqm_pkg::doorbell_t        db_i,
  output logic                      db_ready_o,
  input  logic [2:0]                mtu_code_i,
  output logic                      m_axi_arvalid_o,
  output logic [63:0]               m_axi_araddr_o,
  input  logic                      m_axi_arready_i,
  input  logic                      m_axi_rvalid_i,
  input  logic [wqm_pkg::WQE_W-1:0] m_axi_rdata_i,
  input  logic                      m_axi_rlast_i,
  output logic                      m_axi_rready_o,
  output logic                      sq_req_valid_o,
  output wqm_pkg::sq_req_t          sq_req_o,
  input  logic                      sq_req_ready_i
);

  import wqm_pkg::*;

  // Doorbell to fetch
  logic       fetch_valid;
  logic       fetch_ready;
  fetch_req_t fetch;

  // Fetch to segmenter
  logic       wqe_valid;
  logic       wqe_ready;
  wqe_t       wqe;

  sq_doorbell i_sq_doorbell (
    .axil_aclk_i   (axil_aclk_i),
    .rstn_i        (rstn_i),
    .db_valid_i    (db_valid_i),
    .db_i          (db_i),
    .db_ready_o    (db_ready_o),
    .fetch_valid_o (fetch_valid),
    .fetch_o       (fetch),
    .fetch_ready_i (fetch_ready)
  );

  wqe_fetch i_wqe_fetch (
    .axil_aclk_i     (axil_aclk_i),
    .rstn_i          (rstn_i),
    .fetch_valid_i   (fetch_valid),
    .fetch_i         (fetch),
    .fetch_ready_o   (fetch_ready),
    .m_axi_arvalid_o (m_axi_arvalid_o),
    .m_axi_araddr_o  (m_axi_araddr_o),
    .m_axi_arready_i (m_axi_arready_i),
    .m_axi_rvalid_i  (m_axi_rvalid_i),
    .m_axi_rdata_i   (m_axi_rdata_i),
    .m_axi_rlast_i   (m_axi_rlast_i),
    .m_axi_rready_o  (m_axi_rready_o),
    .wqe_valid_o     (wqe_valid),
    .wqe_o           (wqe),
    .wqe_ready_i     (wqe_ready)
  );

  wqe_segmenter i_wqe_segmenter (
    .axil_aclk_i (axil_aclk_i),
    .rstn_i      (rstn_i),
    .mtu_code_i  (mtu_code_i),
    .wqe_valid_i (wqe_valid),
    .wqe_i       (wqe),
    .wqe_ready_o (wqe_ready),
    .req_valid_o (sq_req_valid_o),
    .req_o       (sq_req_o),
    .req_ready_i (sq_req_ready_i)
  );

endmodule

/* hw/wqe_fetch.sv */
`timescale 1ns/1ns

module wqe_fetch (
  input  logic                      axil_aclk_i,
  input  logic                      rstn_i,
  input  logic                      fetch_valid_i,
  input  wqm_pkg::fetch_req_t       fetch_i,
  output logic                      fetch_ready_o,
  output logic                      m_axi_arvalid_o,
  output logic [63:0]               m_axi_araddr_o,
  input  logic                      m_axi_arready_i,
  input  logic                      m_axi_rvalid_i,
  input  logic [wqm_pkg::WQE_W-1:0] m_axi_rdata_i,
  input  logic                      m_axi_rlast_i,
  output logic                      m_axi_rready_o,
  output logic                      wqe_valid_o,
  output wqm_pkg::wqe_t             wqe_o,
  input  logic                      wqe_ready_i
);

  import wqm_pkg::*;

  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_ADDR,
    FETCH_READ,
    FETCH_HOLD
  } fetch_state_e;

  fetch_state_e state_q;
  fetch_req_t   req_q;
  wqe_t         wqe_q;

  // One request in flight, taken only while the WQE register is empty
  assign fetch_ready_o   = (state_q == FETCH_IDLE);
  assign m_axi_arvalid_o = (state_q == FETCH_ADDR);
  assign m_axi_rready_o  = (state_q == FETCH_READ);
  assign wqe_valid_o     = (state_q == FETCH_HOLD);

  always_ff @(posedge axil_aclk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      state_q <= FETCH_IDLE;
    end else begin
      case (state_q)
        FETCH_IDLE: if (fetch_valid_i) state_q <= FETCH_ADDR;
        FETCH_ADDR: if (m_axi_arready_i) state_q <= FETCH_READ;
        FETCH_READ: if (m_axi_rvalid_i && m_axi_rlast_i) state_q <= FETCH_HOLD;
        FETCH_HOLD: if (wqe_ready_i) state_q <= FETCH_IDLE;
        default:    state_q <= FETCH_IDLE;
      endcase
    end
  end

  //////////////////////////////
  // Request and WQE capture
  //////////////////////////////

  always_ff @(posedge axil_aclk_i) begin
    if (fetch_ready_o && fetch_valid_i) begin
      req_q <= fetch_i;
    end
    if (m_axi_rready_o && m_axi_rvalid_i) begin
      wqe_q.sq_idx       <= req_q.sq_idx;
      wqe_q.local_vaddr  <= req_q.local_vaddr;
      wqe_q.opcode       <= wqe_opcode_e'(m_axi_rdata_i[WQE_OP_LSB +: 8]);
      wqe_q.length       <= m_axi_rdata_i[WQE_LEN_LSB +: LEN_W];
      wqe_q.remote_vaddr <= m_axi_rdata_i[WQE_RVADDR_LSB +: ADDR_W];
    end
  end

  assign m_axi_araddr_o = req_q.wqe_addr;
  assign wqe_o          = wqe_q;

endmodule

/* hw/wqe_segmenter.sv */
`timescale 1ns/1ns

module wqe_segmenter (
  input  logic              axil_aclk_i,
  input  logic              rstn_i,
  input  logic [2:0]        mtu_code_i,
  input  logic              wqe_valid_i,
  input  wqm_pkg::wqe_t     wqe_i,
  output logic              wqe_ready_o,
  output logic              req_valid_o,
  output wqm_pkg::sq_req_t  req_o,
  input  logic              req_ready_i
);

  import wqm_pkg::*;

  typedef enum logic {
    SEG_IDLE,
    SEG_EMIT
  } seg_state_e;

  seg_state_e          state_q;
  logic [2:0]          mtu_code_c;
  logic [LEN_W-1:0]    mtu;
  logic [LEN_W-1:0]    mtu_q;
  logic [LEN_W-1:0]    rem_len_q;
  logic [ADDR_W-1:0]   lvaddr_q;
  logic [ADDR_W-1:0]   rvaddr_q;
  logic [SQ_IDX_W-1:0] sq_idx_q;
  logic                is_read_q;
  logic                first_q;
  logic                wqe_accept;
  logic                op_known;
  logic                req_fire;

  //////////////////////////////
  // MTU
  //////////////////////////////

  // Codes above the limit fall back to the largest MTU
  assign mtu_code_c = (mtu_code_i > 3'(MTU_CODE_MAX)) ? 3'(MTU_CODE_MAX) : mtu_code_i;
  assign mtu        = LEN_W'(MTU_BASE) << mtu_code_c;

  assign wqe_ready_o = (state_q == SEG_IDLE);
  assign wqe_accept  = wqe_ready_o && wqe_valid_i;
  assign op_known    = (wqe_i.opcode == WQE_WRITE) || (wqe_i.opcode == WQE_READ);
  assign req_valid_o = (state_q == SEG_EMIT);
  assign req_fire    = req_valid_o && req_ready_i;

  //////////////////////////////
  // Segment build
  //////////////////////////////

  always_comb begin
    req_o.qpn          = QPN_W'(sq_idx_q);
    req_o.local_vaddr  = lvaddr_q;
    req_o.remote_vaddr = rvaddr_q;
    if (is_read_q) begin
      req_o.opcode = READ_REQ;
      req_o.last   = 1'b1;
      req_o.length = rem_len_q;
    end else if (rem_len_q <= mtu_q) begin
      // Remainder fits in one packet
      if (first_q) begin
        req_o.opcode = WRITE_ONLY;
      end else begin
        req_o.opcode = WRITE_LAST;
      end
      req_o.last   = 1'b1;
      req_o.length = rem_len_q;
    end else begin
      if (first_q) begin
        req_o.opcode = WRITE_FIRST;
      end else begin
        req_o.opcode = WRITE_MIDDLE;
      end
      req_o.last   = 1'b0;
      req_o.length = mtu_q;
    end
  end

  //////////////////////////////
  // Control
  //////////////////////////////

  always_ff @(posedge axil_aclk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      state_q <= SEG_IDLE;
      first_q <= 1'b1;
    end else begin
      case (state_q)
        SEG_IDLE: begin
          // Unknown opcodes are dropped here
          if (wqe_accept && op_known) begin
            state_q <= SEG_EMIT;
            first_q <= 1'b1;
          end
        end
        SEG_EMIT: begin
          if (req_fire) begin
            first_q <= 1'b0;
            if (req_o.last) begin
              state_q <= SEG_IDLE;
            end
          end
        end
        default: state_q <= SEG_IDLE;
      endcase
    end
  end

  // Running length and addresses
  always_ff @(posedge axil_aclk_i) begin
    if (wqe_accept) begin
      mtu_q     <= mtu;
      rem_len_q <= wqe_i.length;
      lvaddr_q  <= wqe_i.local_vaddr;
      rvaddr_q  <= wqe_i.remote_vaddr;
      sq_idx_q  <= wqe_i.sq_idx;
      is_read_q <= (wqe_i.opcode == WQE_READ);
    end else if (req_fire && !req_o.last) begin
      rem_len_q <= rem_len_q - mtu_q;
      lvaddr_q  <= lvaddr_q + ADDR_W'(mtu_q);
      rvaddr_q  <= rvaddr_q + ADDR_W'(mtu_q);
    end
  end

endmodule

/* hw/wqm_pkg.sv */
package wqm_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  localparam int NUM_SQ       = 8;
  localparam int SQ_IDX_W     = 3;
  localparam int WQE_BYTES    = 64;
  localparam int WQE_W        = 512;
  localparam int ADDR_W       = 64;
  localparam int IDX_W        = 32;
  localparam int LEN_W        = 32;
  localparam int QPN_W        = 24;

  // MTU in bytes is MTU_BASE << code
  localparam int MTU_CODE_MAX = 4;
  localparam int MTU_BASE     = 256;

  // Field positions inside a fetched WQE
  localparam int WQE_LEN_LSB    = 96;
  localparam int WQE_OP_LSB     = 128;
  localparam int WQE_RVADDR_LSB = 160;

  //////////////////////////////
  // Opcodes
  //////////////////////////////

  typedef enum logic [7:0] {
    WQE_WRITE = 8'h00,
    WQE_READ  = 8'h04
  } wqe_opcode_e;

  typedef enum logic [4:0] {
    WRITE_FIRST  = 5'h06,
    WRITE_MIDDLE = 5'h07,
    WRITE_LAST   = 5'h08,
    WRITE_ONLY   = 5'h0a,
    READ_REQ     = 5'h0c
  } req_opcode_e;

  //////////////////////////////
  // Link payloads
  //////////////////////////////

  typedef struct packed {
    logic [SQ_IDX_W-1:0] sq_idx;
    logic [IDX_W-1:0]    prod_idx;
    logic [ADDR_W-1:0]   base_addr;
    logic [ADDR_W-1:0]   local_vaddr;
  } doorbell_t;

  typedef struct packed {
    logic [SQ_IDX_W-1:0] sq_idx;
    logic [ADDR_W-1:0]   wqe_addr;
    logic [ADDR_W-1:0]   local_vaddr;
  } fetch_req_t;

  typedef struct packed {
    logic [SQ_IDX_W-1:0] sq_idx;
    logic [ADDR_W-1:0]   local_vaddr;
    wqe_opcode_e         opcode;
    logic [LEN_W-1:0]    length;
    logic [ADDR_W-1:0]   remote_vaddr;
  } wqe_t;

  typedef struct packed {
    req_opcode_e         opcode;
    logic [QPN_W-1:0]    qpn;
    logic                last;
    logic [ADDR_W-1:0]   local_vaddr;
    logic [ADDR_W-1:0]   remote_vaddr;
    logic [LEN_W-1:0]    length;
  } sq_req_t;

endpackage

/* run_sim.sh */
#!/bin/sh
# Build and run the work-queue manager testbench with Verilator
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_wq_manager \
  -f wq_manager.f -o sim_wq_manager > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_wq_manager > sim.log 2>&1 || echo "Simulator exited with an error"
cat sim.log
grep -q 'Test failures found' sim.log && { echo "Simulation failed"; exit 1; }
grep -q 'All tests passed!' sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation passed"

/* verif/tb_wq_manager.sv */
`timescale 1ns/1ns

module tb_wq_manager;

  import wqm_pkg::*;

  localparam int    CLK_PERIOD = 100;
  localparam int    WAIT_LIMIT = 5000;
  localparam int    SETTLE     = 20;
  localparam string DATA_FILE  = "verif/wq_manager_testdata.txt";

  logic               clk = 1'b0;
  logic               rstn;
  logic               db_valid;
  doorbell_t          db;
  logic               db_ready;
  logic [2:0]         mtu_code;
  logic               arvalid;
  logic [63:0]        araddr;
  logic               arready;
  logic               rvalid;
  logic [WQE_W-1:0]   rdata;
  logic               rlast;
  logic               rready;
  logic               req_valid;
  sq_req_t            req;
  logic               req_ready;

  // Memory image, request log and expectations
  logic [WQE_W-1:0]   wqe_mem [logic [63:0]];
  logic [63:0]        ar_log [$];
  logic [63:0]        exp_ar_q [$];
  sq_req_t            got_q [$];
  sq_req_t            exp_q [$];
  logic [31:0]        sq_prod [NUM_SQ];
  logic [31:0]        lcg_state = 32'h9537f48c;
  logic               bp_en = 1'b0;
  logic [255:0]       test_name;
  logic               timed_out;
  int                 bad_reads;
  int                 test_errs;
  int                 tests_run;
  int                 tests_failed;

  wq_manager_top i_dut (
    .axil_aclk_i     (clk),
    .rstn_i          (rstn),
    .db_valid_i      (db_valid),
    .db_i            (db),
    .db_ready_o      (db_ready),
    .mtu_code_i      (mtu_code),
    .m_axi_arvalid_o (arvalid),
    .m_axi_araddr_o  (araddr),
    .m_axi_arready_i (arready),
    .m_axi_rvalid_i  (rvalid),
    .m_axi_rdata_i   (rdata),
    .m_axi_rlast_i   (rlast),
    .m_axi_rready_o  (rready),
    .sq_req_valid_o  (req_valid),
    .sq_req_o        (req),
    .sq_req_ready_i  (req_ready)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Random ready on the request port when back-pressure is on
  always @(posedge clk) begin
    lcg_state <= lcg_next(lcg_state);
    req_ready <= bp_en ? lcg_state[28] : 1'b1;
  end

  //////////////////////////////
  // AXI memory model
  //////////////////////////////

  always @(posedge clk) begin
    if (!rstn) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
      rlast   <= 1'b0;
    end else begin
      // Address channel stalls too under back-pressure
      arready <= bp_en ? lcg_state[20] : 1'b1;
      if (arvalid && arready) begin
        ar_log.push_back(araddr);
        if (wqe_mem.exists(araddr)) begin
          rdata <= wqe_mem[araddr];
        end else begin
          // Address-dependent junk with an opcode nobody serves
          rdata          <= {8{araddr}};
          rdata[135:128] <= 8'hff;
          bad_reads++;
          $display("Read from address %h that holds no WQE", araddr);
        end
        rvalid <= 1'b1;
        rlast  <= 1'b1;
      end else if (rvalid && rready) begin
        rvalid <= 1'b0;
        rlast  <= 1'b0;
      end
    end
  end

  // Request monitor
  always @(posedge clk) begin
    if (rstn && req_valid && req_ready) begin
      got_q.push_back(req);
    end
  end

  function automatic logic [WQE_W-1:0] build_wqe(input logic [7:0] op,
                                                 input logic [31:0] len,
                                                 input logic [63:0] rv);
    logic [WQE_W-1:0] w;
    w            = '0;
    w[127:96]    = len;
    w[135:128]   = op;
    w[223:160]   = rv;
    return w;
  endfunction

  task automatic check_field(input string what, input logic [63:0] exp,
                             input logic [63:0] act);
    assert (exp == act) else begin
      $display("FAIL %0s %0s expected %0h actual %0h", test_name, what, exp, act);
      test_errs++;
    end
  endtask

  // Segments one WQE by the MTU rules into exp_q
  task automatic add_expected(input logic [7:0] op, input logic [31:0] len,
                              input logic [63:0] rv, input logic [2:0] sq,
                              input logic [63:0] lv, input logic [2:0] code);
    sq_req_t     r;
    logic [31:0] mtu;
    logic [31:0] rem;
    logic        first;
    mtu            = 32'd256 << ((code > 3'(MTU_CODE_MAX)) ? 3'(MTU_CODE_MAX) : code);
    r.qpn          = {21'd0, sq};
    r.local_vaddr  = lv;
    r.remote_vaddr = rv;
    if (op == 8'h04) begin
      r.opcode = READ_REQ;
      r.last   = 1'b1;
      r.length = len;
      exp_q.push_back(r);
    end else if (op == 8'h00) begin
      rem   = len;
      first = 1'b1;
      while (rem > mtu) begin
        r.opcode = first ? WRITE_FIRST : WRITE_MIDDLE;
        r.last   = 1'b0;
        r.length = mtu;
        exp_q.push_back(r);
        rem            = rem - mtu;
        r.local_vaddr  = r.local_vaddr + 64'(mtu);
        r.remote_vaddr = r.remote_vaddr + 64'(mtu);
        first          = 1'b0;
      end
      r.opcode = first ? WRITE_ONLY : WRITE_LAST;
      r.last   = 1'b1;
      r.length = rem;
      exp_q.push_back(r);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout in %0s while waiting for %0s", test_name, what);
    tests_run++;
    tests_failed++;
    timed_out = 1'b1;
  endtask

  //////////////////////////////
  // One test from the data file
  //////////////////////////////

  task automatic run_test(input int fd);
    int          code;
    int          n_wqe;
    int          n_file;
    int          cycles;
    logic [255:0] tok;
    logic [2:0]  t_mtu;
    logic [2:0]  t_sq;
    logic [31:0] t_prod;
    logic [63:0] t_base;
    logic [63:0] t_lv;
    logic        t_bp;
    logic [31:0] old_prod;
    logic [7:0]  w_op;
    logic [31:0] w_len;
    logic [63:0] w_rv;
    logic [31:0] w_cnt;
    logic [63:0] w_addr;
    code = $fscanf(fd, "%s %d %d %d %h %h %d %d", test_name, t_mtu, t_sq, t_prod,
                   t_base, t_lv, t_bp, n_wqe);
    got_q.delete();
    ar_log.delete();
    exp_q.delete();
    exp_ar_q.delete();
    bad_reads = 0;
    test_errs = 0;
    n_file    = 0;
    assert (code == 8) else begin
      $display("Test line of %0s in the test data is incomplete", test_name);
      test_errs++;
    end
    old_prod  = sq_prod[t_sq];
    check_field("new WQE count", (t_prod > old_prod) ? 64'(t_prod - old_prod) : 64'd0,
                64'(n_wqe));
    for (int k = 0; k < n_wqe; k++) begin
      code   = $fscanf(fd, "%s %h %d %h %d", tok, w_op, w_len, w_rv, w_cnt);
      assert (code == 5) else begin
        $display("WQE line %0d of %0s in the test data is incomplete", k, test_name);
        test_errs++;
      end
      w_addr = t_base + 64'(old_prod + 32'(k)) * 64'd64;
      wqe_mem[w_addr] = build_wqe(w_op, w_len, w_rv);
      exp_ar_q.push_back(w_addr);
      add_expected(w_op, w_len, w_rv, t_sq, t_lv, t_mtu);
      n_file += int'(w_cnt);
    end
    if (t_prod > old_prod) begin
      sq_prod[t_sq] = t_prod;
    end
    bp_en = t_bp;

    @(posedge clk);
    mtu_code       <= t_mtu;
    db.sq_idx      <= t_sq;
    db.prod_idx    <= t_prod;
    db.base_addr   <= t_base;
    db.local_vaddr <= t_lv;
    db_valid       <= 1'b1;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (!db_ready && cycles < WAIT_LIMIT);
    if (!db_ready) begin
      report_timeout("doorbell ready");
      return;
    end
    db_valid <= 1'b0;

    cycles = 0;
    while (got_q.size() < exp_q.size() && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (got_q.size() < exp_q.size()) begin
      report_timeout("requests");
      return;
    end
    // Let any surplus request or read show up
    repeat (SETTLE) @(negedge clk);

    check_field("segment count from data file", 64'(n_file), 64'(got_q.size()));
    check_field("request count", 64'(exp_q.size()), 64'(got_q.size()));
    for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
      check_field($sformatf("req %0d opcode", i), 64'(exp_q[i].opcode), 64'(got_q[i].opcode));
      check_field($sformatf("req %0d qpn", i), 64'(exp_q[i].qpn), 64'(got_q[i].qpn));
      check_field($sformatf("req %0d last", i), 64'(exp_q[i].last), 64'(got_q[i].last));
      check_field($sformatf("req %0d length", i), 64'(exp_q[i].length), 64'(got_q[i].length));
      check_field($sformatf("req %0d local vaddr", i), exp_q[i].local_vaddr,
                  got_q[i].local_vaddr);
      check_field($sformatf("req %0d remote vaddr", i), exp_q[i].remote_vaddr,
                  got_q[i].remote_vaddr);
    end
    check_field("AR count", 64'(exp_ar_q.size()), 64'(ar_log.size()));
    for (int i = 0; i < exp_ar_q.size() && i < ar_log.size(); i++) begin
      check_field($sformatf("AR %0d address", i), exp_ar_q[i], ar_log[i]);
    end
    assert (bad_reads == 0) else begin
      $display("Test %0s read memory outside the listed WQEs", test_name);
      test_errs++;
    end

    tests_run++;
    if (test_errs == 0) begin
      $display("Test %0s: ok, %0d requests", test_name, got_q.size());
    end else begin
      $display("Test %0s: %0d checks failed", test_name, test_errs);
      tests_failed++;
    end
  endtask

  initial begin
    int           fd;
    int           code;
    logic [255:0] tok;
    logic [1023:0] line;
    logic         done;
    rstn      = 1'b0;
    db_valid  = 1'b0;
    db        = '0;
    mtu_code  = 3'd0;
    arready   = 1'b0;
    rvalid    = 1'b0;
    rdata     = '0;
    rlast     = 1'b0;
    req_ready = 1'b0;
    tests_run    = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    for (int i = 0; i < NUM_SQ; i++) begin
      sq_prod[i] = '0;
    end
    repeat (10) @(posedge clk);
    rstn <= 1'b1;
    repeat (2) @(negedge clk);

    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open %0s", DATA_FILE);
    end else begin
      done = 1'b0;
      while (!done && !timed_out && !$feof(fd)) begin
        code = $fscanf(fd, "%s", tok);
        if (code != 1) begin
          done = 1'b1;
        end else if (tok == "#") begin
          code = $fgets(line, fd);
        end else if (tok == "test") begin
          run_test(fd);
        end else begin
          $display("Unexpected word %0s in the test data", tok);
          tests_failed++;
        end
      end
      $fclose(fd);
    end

    $display("Summary: %0d tests run, %0d failed", tests_run, tests_failed);
    if (!timed_out && tests_failed == 0 && tests_run > 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* verif/wq_manager_assertions.sv */
`timescale 1ns/1ns

module wq_manager_assertions (
  input logic                 axil_aclk_i,
  input logic                 rstn_i,
  input logic                 fetch_valid_i,
  input logic                 fetch_ready_i,
  input wqm_pkg::fetch_req_t  fetch_i,
  input logic                 wqe_valid_i,
  input logic                 wqe_ready_i,
  input wqm_pkg::wqe_t        wqe_i,
  input logic                 arvalid_i,
  input logic                 arready_i,
  input logic [63:0]          araddr_i,
  input logic                 rready_i,
  input logic                 req_valid_i,
  input logic                 req_ready_i,
  input wqm_pkg::sq_req_t     req_i
);

  // Stalled valids hold with the same payload
  a_fetch_hold: assert property (@(posedge axil_aclk_i) disable iff (!rstn_i)
    fetch_valid_i && !fetch_ready_i |=> fetch_valid_i && $stable(fetch_i))
    else $error("fetch request dropped or changed while stalled");

  a_wqe_hold: assert property (@(posedge axil_aclk_i) disable iff (!rstn_i)
    wqe_valid_i && !wqe_ready_i |=> wqe_valid_i && $stable(wqe_i))
    else $error("WQE dropped or changed while stalled");

  a_req_hold: assert property (@(posedge axil_aclk_i) disable iff (!rstn_i)
    req_valid_i && !req_ready_i |=> req_valid_i && $stable(req_i))
    else $error("request dropped or changed while stalled");

  a_ar_hold: assert property (@(posedge axil_aclk_i) disable iff (!rstn_i)
    arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i))
    else $error("AR dropped or changed while stalled");

  // Address and data phases never overlap
  a_ar_r_excl: assert property (@(posedge axil_aclk_i) disable iff (!rstn_i)
    !(arvalid_i && rready_i))
    else $error("arvalid and rready high together");

endmodule

bind wq_manager_top wq_manager_assertions i_assertions (
  .axil_aclk_i   (axil_aclk_i),
  .rstn_i        (rstn_i),
  .fetch_valid_i (fetch_valid),
  .fetch_ready_i (fetch_ready),
  .fetch_i       (fetch),
  .wqe_valid_i   (wqe_valid),
  .wqe_ready_i   (wqe_ready),
  .wqe_i         (wqe),
  .arvalid_i     (m_axi_arvalid_o),
  .arready_i     (m_axi_arready_i),
  .araddr_i      (m_axi_araddr_o),
  .rready_i      (m_axi_rready_o),
  .req_valid_i   (sq_req_valid_o),
  .req_ready_i   (sq_req_ready_i),
  .req_i         (sq_req_o)
);

/* verif/wq_manager_testdata.txt */
# test name mtu_code queue producer_index base_hex local_vaddr_hex backpressure wqe_lines
# wqe opcode_hex length_dec remote_vaddr_hex expected_segments
test write_only 0 1 1 0000000000010000 00000000a0000000 0 1
wqe 00 200 00000000c0000000 1
test write_split 0 2 1 0000000000020000 00000000a1000000 0 1
wqe 00 1000 00000000c1000000 4
test read_any 0 3 2 0000000000030000 00000000a2000000 0 2
wqe 04 5000 00000000c2000000 1
wqe 04 100 00000000c2100000 1
test three_wqes 2 4 3 0000000000040000 80000000a3000000 0 3
wqe 00 1024 00000000c3000000 1
wqe 00 2500 00000000c3100000 3
wqe 04 64 00000000c3200000 1
test continue_idx 2 4 5 0000000000040000 80000000a3800000 0 2
wqe 00 1025 00000000c3300000 2
wqe 00 16 00000000c3400000 1
test stale_doorbell 0 4 4 0000000000040000 00000000deadbeef 0 0
test unknown_op 1 5 2 0000000000050000 00000000a5000000 0 2
wqe 02 300 00000000c5000000 0
wqe 00 600 00000000c5100000 2
test mtu_clamp 7 6 1 0000000000060000 00000000a6000000 0 1
wqe 00 9000 12345678c6000000 3
test backpressure 0 7 3 0000000000070000 00000000a7000000 1 3
wqe 00 1000 00000000c7000000 4
wqe 04 777 00000000c7100000 1
wqe 00 300 00000000c7200000 2
test bp_same_queue 0 1 3 0000000000010000 00000000a8000000 1 2
wqe 00 1000 00000000c8000000 4
wqe 00 256 00000000c8100000 1

/* wq_manager.f */
hw/wqm_pkg.sv
hw/sq_doorbell.sv
hw/wqe_fetch.sv
hw/wqe_segmenter.sv
hw/wq_manager_top.sv
verif/wq_manager_assertions.sv
verif/tb_wq_manager.sv
